/* nts_extractor_pkg.sv */
package nts_extractor_pkg;

  // ------------------------------------------------
  // Word and byte-lane sizes
  // ------------------------------------------------

  // Engine FIFO and buffer RAM word
  localparam int DATA_W = 64;
  // Byte lanes per word on the MAC side
  localparam int BYTES_W = DATA_W / 8;
  // Last-word byte count, 0 to 8
  localparam int LWDV_W = 4;
  // Widest RAM word address the write struct can carry
  localparam int RAM_ADDR_MAX_W = 16;

  // ------------------------------------------------
  // Buffer descriptor state
  // ------------------------------------------------

  // Ring life cycle of one packet buffer
  typedef enum logic [1:0] {
    BUF_UNUSED  = 2'b00,
    BUF_WRITING = 2'b01,
    BUF_LOADED  = 2'b10,
    BUF_READING = 2'b11
  } buffer_state_e;

  // One RAM write from the engine reader
  // Address holds {buffer index, word index} in its low bits
  typedef struct packed {
    logic                      we;
    logic [RAM_ADDR_MAX_W-1:0] addr;
    logic [DATA_W-1:0]         data;
  } ram_wr_t;

  // One beat towards the MAC transmitter
  typedef struct packed {
    logic [BYTES_W-1:0] valid;
    logic [DATA_W-1:0]  data;
  } mac_beat_t;

  // Last word of a packet
  // The top k bytes move down to lanes 0..k-1, the rest go to zero
  // Counts outside 1..8 give an empty beat
  function automatic mac_beat_t repack_last_word(
    input logic [DATA_W-1:0] word,
    input logic [LWDV_W-1:0] lwdv
  );
    mac_beat_t beat;
    beat = '0;
    if (lwdv != '0 && int'(lwdv) <= BYTES_W) begin
      for (int i = 0; i < BYTES_W; i++) begin
        if (i < int'(lwdv)) begin
          beat.valid[i] = 1'b1;
          beat.data[8*i +: 8] = word[8*(BYTES_W - int'(lwdv) + i) +: 8];
        end
      end
    end
    return beat;
  endfunction

endpackage

/* nts_buffer_ram.sv */
`timescale 1ns/1ps

module nts_buffer_ram #(
  parameter int BUF_SEL_W   = 8,
  parameter int WORD_ADDR_W = 8
) (
  input  logic                                 i_clk,
  // Write port, fed by the reader pipeline register
  input  nts_extractor_pkg::ram_wr_t           i_wr,
  // Read port, transmitter side
  input  logic [BUF_SEL_W+WORD_ADDR_W-1:0]     i_rd_addr,
  output logic [nts_extractor_pkg::DATA_W-1:0] o_rd_data
);
  import nts_extractor_pkg::*;

  localparam int ADDR_W = BUF_SEL_W + WORD_ADDR_W;
  localparam int DEPTH  = 2 ** ADDR_W;

  // Every buffer side by side, buffer index in the upper address bits
  logic [DATA_W-1:0] mem [DEPTH];

  // Write side
  // Only the low address bits are meaningful
  always_ff @(posedge i_clk) begin
    if (i_wr.we) begin
      mem[i_wr.addr[ADDR_W-1:0]] <= i_wr.data;
    end
  end

  // Registered read, one cycle latency
  always_ff @(posedge i_clk) begin
    o_rd_data <= mem[i_rd_addr];
  end

endmodule

/* nts_buffer_table.sv */
`timescale 1ns/1ps

module nts_buffer_table #(
  parameter int BUF_SEL_W   = 8,
  parameter int WORD_ADDR_W = 8
) (
  input  logic                                 i_clk,
  input  logic                                 i_areset,
  // Reader strobes
  input  logic                                 i_claim,
  input  logic [nts_extractor_pkg::LWDV_W-1:0] i_claim_lwdv,
  input  logic                                 i_word_written,
  input  logic                                 i_packet_done,
  // Transmitter status
  input  logic                                 i_tx_idle,
  input  logic                                 i_tx_done,
  output logic                                 o_ready,
  // Writer-side descriptor
  output logic [BUF_SEL_W-1:0]                 o_wr_sel,
  output nts_extractor_pkg::buffer_state_e     o_wr_state,
  output logic [WORD_ADDR_W-1:0]               o_wr_end_addr,
  // Reader-side descriptor and handover
  output logic                                 o_tx_start,
  output logic [BUF_SEL_W-1:0]                 o_rd_sel,
  output logic [WORD_ADDR_W-1:0]               o_rd_end_addr,
  output logic [nts_extractor_pkg::LWDV_W-1:0] o_rd_lwdv
);
  import nts_extractor_pkg::*;

  localparam int NBUF = 2 ** BUF_SEL_W;
  localparam logic [BUF_SEL_W-1:0] SEL_LAST = '1;

  // Descriptor arrays, one entry per buffer
  logic [WORD_ADDR_W-1:0] end_addr_q [NBUF];
  logic [LWDV_W-1:0]      lwdv_q     [NBUF];
  buffer_state_e          state_q    [NBUF];

  // Ring pointers and boot sweep
  logic [BUF_SEL_W-1:0] wr_sel_q;
  logic [BUF_SEL_W-1:0] rd_sel_q;
  logic [BUF_SEL_W-1:0] sweep_q;
  logic                 ready_q;

  buffer_state_e rd_state;

  // ------------------------------------------------
  // Descriptor views
  // ------------------------------------------------

  assign o_ready       = ready_q;
  assign o_wr_sel      = wr_sel_q;
  assign o_wr_state    = state_q[wr_sel_q];
  assign o_wr_end_addr = end_addr_q[wr_sel_q];

  assign rd_state      = state_q[rd_sel_q];
  assign o_rd_sel      = rd_sel_q;
  assign o_rd_end_addr = end_addr_q[rd_sel_q];
  assign o_rd_lwdv     = lwdv_q[rd_sel_q];

  // Hand a loaded buffer to an idle transmitter
  assign o_tx_start = ready_q && rd_state == BUF_LOADED && i_tx_idle;

  // ------------------------------------------------
  // Pointers and sweep counter
  // ------------------------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      ready_q  <= 1'b0;
      sweep_q  <= '0;
      wr_sel_q <= '0;
      rd_sel_q <= '0;
    end else begin
      // One descriptor per cycle until the last one is cleared
      if (!ready_q) begin
        if (sweep_q == SEL_LAST) begin
          ready_q <= 1'b1;
        end else begin
          sweep_q <= sweep_q + 1'b1;
        end
      end
      // Both rings wrap naturally
      if (i_packet_done) begin
        wr_sel_q <= wr_sel_q + 1'b1;
      end
      if (i_tx_done) begin
        rd_sel_q <= rd_sel_q + 1'b1;
      end
    end
  end

  // ------------------------------------------------
  // Descriptor updates
  // ------------------------------------------------

  // Writer and reader never touch the same entry in one cycle
  // The state decides which side owns it
  always_ff @(posedge i_clk) begin
    if (!ready_q) begin
      end_addr_q[sweep_q] <= '0;
      lwdv_q[sweep_q]     <= '0;
      state_q[sweep_q]    <= BUF_UNUSED;
    end else begin
      // Writer side
      if (i_claim) begin
        end_addr_q[wr_sel_q] <= '0;
        lwdv_q[wr_sel_q]     <= i_claim_lwdv;
        state_q[wr_sel_q]    <= BUF_WRITING;
      end
      if (i_word_written) begin
        end_addr_q[wr_sel_q] <= end_addr_q[wr_sel_q] + 1'b1;
      end
      if (i_packet_done) begin
        state_q[wr_sel_q] <= BUF_LOADED;
      end
      // Transmitter side
      if (o_tx_start) begin
        state_q[rd_sel_q] <= BUF_READING;
      end
      if (i_tx_done) begin
        state_q[rd_sel_q] <= BUF_UNUSED;
      end
    end
  end

  // Reader only fills a buffer it has claimed
  a_write_owned: assert property (@(posedge i_clk) disable iff (i_areset)
    i_word_written |-> state_q[wr_sel_q] == BUF_WRITING);

  // Transmitter only finishes the buffer it was handed
  a_done_owned: assert property (@(posedge i_clk) disable iff (i_areset)
    i_tx_done |-> rd_state == BUF_READING);

endmodule

/* nts_engine_reader.sv */
`timescale 1ns/1ps

module nts_engine_reader #(
  parameter int BUF_SEL_W   = 8,
  parameter int WORD_ADDR_W = 8
) (
  input  logic                                 i_clk,
  input  logic                                 i_areset,
  input  logic                                 i_ready,
  // Engine FIFO
  input  logic                                 i_packet_available,
  input  logic                                 i_fifo_empty,
  input  logic [nts_extractor_pkg::DATA_W-1:0] i_fifo_rd_data,
  input  logic [nts_extractor_pkg::LWDV_W-1:0] i_bytes_last_word,
  // Current writer descriptor
  input  logic [BUF_SEL_W-1:0]                 i_buf_sel,
  input  nts_extractor_pkg::buffer_state_e     i_buf_state,
  input  logic [WORD_ADDR_W-1:0]               i_buf_end_addr,
  output logic                                 o_fifo_rd_en,
  output logic                                 o_packet_read,
  // Strobes to the descriptor table
  output logic                                 o_claim,
  output logic [nts_extractor_pkg::LWDV_W-1:0] o_claim_lwdv,
  output logic                                 o_word_written,
  output logic                                 o_packet_done,
  output nts_extractor_pkg::ram_wr_t           o_ram_wr
);
  import nts_extractor_pkg::*;

  logic    rd_en_d;
  logic    pkt_read_d;
  ram_wr_t wr_d;

  // Byte count is latched by the table on claim
  assign o_claim_lwdv = i_bytes_last_word;

  // ------------------------------------------------
  // Claim, copy or finish
  // ------------------------------------------------

  always_comb begin
    o_claim        = 1'b0;
    o_word_written = 1'b0;
    o_packet_done  = 1'b0;
    rd_en_d        = 1'b0;
    pkt_read_d     = 1'b0;
    wr_d           = '0;
    if (i_ready) begin
      case (i_buf_state)
        // Free buffer and a packet waiting at the head
        BUF_UNUSED: begin
          if (i_packet_available && !i_fifo_empty) begin
            o_claim = 1'b1;
            rd_en_d = 1'b1;
          end
        end
        BUF_WRITING: begin
          if (i_fifo_empty) begin
            // Packet fully copied
            o_packet_done = 1'b1;
            pkt_read_d    = 1'b1;
          end else begin
            // Head word goes to {buffer, end address}
            o_word_written = 1'b1;
            rd_en_d        = 1'b1;
            wr_d.we        = 1'b1;
            wr_d.addr      = RAM_ADDR_MAX_W'({i_buf_sel, i_buf_end_addr});
            wr_d.data      = i_fifo_rd_data;
          end
        end
        // Loaded or reading buffer stalls until the ring frees it
        default: ;
      endcase
    end
  end

  // Write pipeline register and engine strobes
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      o_fifo_rd_en  <= 1'b0;
      o_packet_read <= 1'b0;
      o_ram_wr      <= '0;
    end else begin
      o_fifo_rd_en  <= rd_en_d;
      o_packet_read <= pkt_read_d;
      o_ram_wr      <= wr_d;
    end
  end

  // A finished packet holds at least two words
  a_min_packet: assert property (@(posedge i_clk) disable iff (i_areset)
    o_packet_done |-> i_buf_end_addr >= WORD_ADDR_W'(2));

endmodule

/* nts_mac_tx.sv */
`timescale 1ns/1ps

module nts_mac_tx #(
  parameter int BUF_SEL_W   = 8,
  parameter int WORD_ADDR_W = 8
) (
  input  logic                                  i_clk,
  input  logic                                  i_areset,
  input  logic                                  i_ready,
  // Handover from the descriptor table
  input  logic                                  i_tx_start,
  input  logic [BUF_SEL_W-1:0]                  i_buf_sel,
  input  logic [WORD_ADDR_W-1:0]                i_end_addr,
  input  logic [nts_extractor_pkg::LWDV_W-1:0]  i_lwdv,
  // Buffer RAM read port
  input  logic [nts_extractor_pkg::DATA_W-1:0]  i_ram_rd_data,
  input  logic                                  i_mac_tx_ack,
  output logic                                  o_tx_idle,
  output logic                                  o_tx_done,
  output logic [BUF_SEL_W+WORD_ADDR_W-1:0]      o_ram_rd_addr,
  // MAC transmitter
  output logic                                  o_mac_tx_start,
  output logic [nts_extractor_pkg::BYTES_W-1:0] o_mac_tx_data_valid,
  output logic [nts_extractor_pkg::DATA_W-1:0]  o_mac_tx_data
);
  import nts_extractor_pkg::*;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_AWAIT_ACK,
    TX_WRITE,
    TX_WRITE_LAST
  } tx_state_e;

  tx_state_e state_q;
  tx_state_e state_d;

  // Word address of the next RAM read inside the buffer
  logic [WORD_ADDR_W-1:0] addr_q;
  logic [WORD_ADDR_W-1:0] addr_d;
  logic [WORD_ADDR_W-1:0] addr_nxt;

  logic      start_d;
  logic      start_q;
  mac_beat_t beat_d;
  mac_beat_t beat_q;

  assign o_tx_idle     = state_q == TX_IDLE;
  assign o_tx_done     = state_q == TX_WRITE_LAST;
  assign o_ram_rd_addr = {i_buf_sel, addr_q};

  assign o_mac_tx_start      = start_q;
  assign o_mac_tx_data_valid = beat_q.valid;
  assign o_mac_tx_data       = beat_q.data;

  // ------------------------------------------------
  // Transmit FSM
  // ------------------------------------------------

  always_comb begin
    state_d  = state_q;
    addr_d   = addr_q;
    start_d  = 1'b0;
    beat_d   = '0;
    addr_nxt = addr_q + 1'b1;
    case (state_q)
      TX_IDLE: begin
        if (i_ready && i_tx_start) begin
          start_d = 1'b1;
          addr_d  = '0;
          state_d = TX_AWAIT_ACK;
        end
      end
      // Word 0 is presented while waiting and is ready on ack
      TX_AWAIT_ACK: begin
        if (i_mac_tx_ack) begin
          addr_d  = WORD_ADDR_W'(1);
          state_d = TX_WRITE;
        end
      end
      // RAM shows the word before addr_q as a full beat
      TX_WRITE: begin
        beat_d.valid = '1;
        beat_d.data  = i_ram_rd_data;
        addr_d       = addr_nxt;
        // Next word read is the last one of the packet
        if (addr_nxt >= i_end_addr) begin
          state_d = TX_WRITE_LAST;
        end
      end
      TX_WRITE_LAST: begin
        beat_d  = repack_last_word(i_ram_rd_data, i_lwdv);
        state_d = TX_IDLE;
      end
      default: state_d = TX_IDLE;
    endcase
  end

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state_q <= TX_IDLE;
      addr_q  <= '0;
      start_q <= 1'b0;
      beat_q  <= '0;
    end else begin
      state_q <= state_d;
      addr_q  <= addr_d;
      start_q <= start_d;
      beat_q  <= beat_d;
    end
  end

  // Last word never holds more bytes than one word has
  a_lwdv_in_range: assert property (@(posedge i_clk) disable iff (i_areset)
    state_q == TX_WRITE_LAST |-> i_lwdv <= LWDV_W'(BYTES_W));

endmodule

/* nts_extractor.sv */
`timescale 1ns/1ps

module nts_extractor #(
  parameter int BUF_SEL_W   = 8,
  parameter int WORD_ADDR_W = 8
) (
  input  logic                                 i_clk,
  input  logic                                 i_areset,
  // Engine FIFO side
  input  logic                                 i_engine_packet_available,
  input  logic                                 i_engine_fifo_empty,
  input  logic [nts_extractor_pkg::DATA_W-1:0] i_engine_fifo_rd_data,
  input  logic [nts_extractor_pkg::LWDV_W-1:0] i_engine_bytes_last_word,
  output logic                                 o_engine_fifo_rd_en,
  output logic                                 o_engine_packet_read,
  // MAC transmitter side
  output logic                                  o_mac_tx_start,
  input  logic                                  i_mac_tx_ack,
  output logic [nts_extractor_pkg::BYTES_W-1:0] o_mac_tx_data_valid,
  output logic [nts_extractor_pkg::DATA_W-1:0]  o_mac_tx_data
);
  import nts_extractor_pkg::*;

  localparam int RAM_AW = BUF_SEL_W + WORD_ADDR_W;

  // Boot sweep done
  logic ready;

  // Writer descriptor and reader strobes
  logic [BUF_SEL_W-1:0]   wr_sel;
  buffer_state_e          wr_state;
  logic [WORD_ADDR_W-1:0] wr_end_addr;
  logic                   claim;
  logic [LWDV_W-1:0]      claim_lwdv;
  logic                   word_written;
  logic                   packet_done;
  ram_wr_t                ram_wr;

  // Transmitter descriptor and handover
  logic                   tx_start;
  logic                   tx_idle;
  logic                   tx_done;
  logic [BUF_SEL_W-1:0]   rd_sel;
  logic [WORD_ADDR_W-1:0] rd_end_addr;
  logic [LWDV_W-1:0]      rd_lwdv;
  logic [RAM_AW-1:0]      ram_rd_addr;
  logic [DATA_W-1:0]      ram_rd_data;

  nts_buffer_table #(
    .BUF_SEL_W   (BUF_SEL_W),
    .WORD_ADDR_W (WORD_ADDR_W)
  ) u_table (
    .i_clk          (i_clk),
    .i_areset       (i_areset),
    .i_claim        (claim),
    .i_claim_lwdv   (claim_lwdv),
    .i_word_written (word_written),
    .i_packet_done  (packet_done),
    .i_tx_idle      (tx_idle),
    .i_tx_done      (tx_done),
    .o_ready        (ready),
    .o_wr_sel       (wr_sel),
    .o_wr_state     (wr_state),
    .o_wr_end_addr  (wr_end_addr),
    .o_tx_start     (tx_start),
    .o_rd_sel       (rd_sel),
    .o_rd_end_addr  (rd_end_addr),
    .o_rd_lwdv      (rd_lwdv)
  );

  nts_engine_reader #(
    .BUF_SEL_W   (BUF_SEL_W),
    .WORD_ADDR_W (WORD_ADDR_W)
  ) u_reader (
    .i_clk              (i_clk),
    .i_areset           (i_areset),
    .i_ready            (ready),
    .i_packet_available (i_engine_packet_available),
    .i_fifo_empty       (i_engine_fifo_empty),
    .i_fifo_rd_data     (i_engine_fifo_rd_data),
    .i_bytes_last_word  (i_engine_bytes_last_word),
    .i_buf_sel          (wr_sel),
    .i_buf_state        (wr_state),
    .i_buf_end_addr     (wr_end_addr),
    .o_fifo_rd_en       (o_engine_fifo_rd_en),
    .o_packet_read      (o_engine_packet_read),
    .o_claim            (claim),
    .o_claim_lwdv       (claim_lwdv),
    .o_word_written     (word_written),
    .o_packet_done      (packet_done),
    .o_ram_wr           (ram_wr)
  );

  nts_buffer_ram #(
    .BUF_SEL_W   (BUF_SEL_W),
    .WORD_ADDR_W (WORD_ADDR_W)
  ) u_ram (
    .i_clk     (i_clk),
    .i_wr      (ram_wr),
    .i_rd_addr (ram_rd_addr),
    .o_rd_data (ram_rd_data)
  );

  nts_mac_tx #(
    .BUF_SEL_W   (BUF_SEL_W),
    .WORD_ADDR_W (WORD_ADDR_W)
  ) u_mac_tx (
    .i_clk               (i_clk),
    .i_areset            (i_areset),
    .i_ready             (ready),
    .i_tx_start          (tx_start),
    .i_buf_sel           (rd_sel),
    .i_end_addr          (rd_end_addr),
    .i_lwdv              (rd_lwdv),
    .i_ram_rd_data       (ram_rd_data),
    .i_mac_tx_ack        (i_mac_tx_ack),
    .o_tx_idle           (tx_idle),
    .o_tx_done           (tx_done),
    .o_ram_rd_addr       (ram_rd_addr),
    .o_mac_tx_start      (o_mac_tx_start),
    .o_mac_tx_data_valid (o_mac_tx_data_valid),
    .o_mac_tx_data       (o_mac_tx_data)
  );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 2
) (
  output logic o_clk,
  output logic o_areset
);

  // Free-running clock, low at time zero
  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // Reset covers the first rising edges
  // Released on a falling edge, away from the DUT clock edge
  initial begin
    o_areset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_areset = 1'b0;
  end

endmodule

/* tb_nts_extractor.sv */
`timescale 1ns/1ps

module tb_nts_extractor;
  import nts_extractor_pkg::*;

  // Four buffers let a held ack fill the ring quickly
  localparam int BUF_SEL_W    = 2;
  localparam int WORD_ADDR_W  = 4;
  localparam int BEAT_W       = BYTES_W + DATA_W;
  localparam int NUM_PKT      = 40;
  // Packet whose ack is held back long
  localparam int HOLD_IDX     = 16;
  localparam int HOLD_CYCLES  = 300;
  localparam int QUIET_CYCLES = 20;
  localparam int WAIT_LIMIT   = 2000;
  localparam logic [31:0] LFSR_SEED = 32'h3e6729dc;

  logic clk;
  logic areset;

  logic                 i_engine_packet_available;
  logic                 i_engine_fifo_empty;
  logic [DATA_W-1:0]    i_engine_fifo_rd_data;
  logic [LWDV_W-1:0]    i_engine_bytes_last_word;
  logic                 o_engine_fifo_rd_en;
  logic                 o_engine_packet_read;
  logic                 o_mac_tx_start;
  logic                 i_mac_tx_ack;
  logic [BYTES_W-1:0]   o_mac_tx_data_valid;
  logic [DATA_W-1:0]    o_mac_tx_data;

  // Engine FIFO model holding the words of the packet at the head
  logic [DATA_W-1:0] fifo_q [$];
  logic [LWDV_W-1:0] fifo_lwdv;
  logic              pop_pending;

  // Expected beats and lengths of every sent packet
  logic [BEAT_W-1:0] exp_beats [$];
  int                exp_len [$];
  int                ack_delay [NUM_PKT];

  logic [31:0] lfsr_q;
  int          mismatch_count;
  int          failure_count;
  int          pkt_read_count;
  int          start_count;
  bit          mac_done;

  tb_clock_gen #(
    .PERIOD_NS    (8),
    .RESET_CYCLES (2)
  ) u_clock_gen (
    .o_clk    (clk),
    .o_areset (areset)
  );

  nts_extractor #(
    .BUF_SEL_W   (BUF_SEL_W),
    .WORD_ADDR_W (WORD_ADDR_W)
  ) u_dut (
    .i_clk                     (clk),
    .i_areset                  (areset),
    .i_engine_packet_available (i_engine_packet_available),
    .i_engine_fifo_empty       (i_engine_fifo_empty),
    .i_engine_fifo_rd_data     (i_engine_fifo_rd_data),
    .i_engine_bytes_last_word  (i_engine_bytes_last_word),
    .o_engine_fifo_rd_en       (o_engine_fifo_rd_en),
    .o_engine_packet_read      (o_engine_packet_read),
    .o_mac_tx_start            (o_mac_tx_start),
    .i_mac_tx_ack              (i_mac_tx_ack),
    .o_mac_tx_data_valid       (o_mac_tx_data_valid),
    .o_mac_tx_data             (o_mac_tx_data)
  );

  // ------------------------------------------------
  // Random source and reference model
  // ------------------------------------------------

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit
  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[62:0], lfsr_q[0]};
    end
  endtask

  // Beat the MAC should get for one stored word
  function automatic logic [BEAT_W-1:0] expected_beat(
    input logic [DATA_W-1:0] word,
    input bit                last,
    input logic [LWDV_W-1:0] k
  );
    logic [BYTES_W-1:0] mask;
    logic [DATA_W-1:0]  data;
    if (!last) begin
      return {{BYTES_W{1'b1}}, word};
    end
    if (k == '0 || int'(k) > BYTES_W) begin
      return '0;
    end
    // Top k bytes shifted down to the low lanes
    data = word >> (8 * (BYTES_W - int'(k)));
    mask = BYTES_W'((1 << int'(k)) - 1);
    return {mask, data};
  endfunction

  // ------------------------------------------------
  // Checks and end of run
  // ------------------------------------------------

  task automatic check_value(input string name, input logic [BEAT_W-1:0] got,
                             input logic [BEAT_W-1:0] want);
    if (got !== want) begin
      mismatch_count++;
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, want);
    end
  endtask

  task automatic finish_run();
    $display("Summary: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  task automatic abort_run(input string why);
    failure_count++;
    $display("At %0t ns: %s", $time, why);
    finish_run();
  endtask

  // MAC data lanes idle
  task automatic check_mac_idle();
    check_value("o_mac_tx_data_valid", BEAT_W'(o_mac_tx_data_valid), '0);
    check_value("o_mac_tx_data", BEAT_W'(o_mac_tx_data), '0);
  endtask

  // Nothing acts while no packet is offered
  task automatic check_quiet();
    check_value("o_engine_fifo_rd_en", BEAT_W'(o_engine_fifo_rd_en), '0);
    check_value("o_engine_packet_read", BEAT_W'(o_engine_packet_read), '0);
    check_value("o_mac_tx_start", BEAT_W'(o_mac_tx_start), '0);
    check_mac_idle();
  endtask

  // ------------------------------------------------
  // Engine FIFO side
  // ------------------------------------------------

  // Called on each falling edge
  // A pop seen in the last cycle takes effect before the head is shown
  task automatic engine_step();
    if (pop_pending && fifo_q.size() > 0) begin
      void'(fifo_q.pop_front());
    end
    pop_pending = o_engine_fifo_rd_en;
    if (o_engine_packet_read) begin
      pkt_read_count++;
    end
    // Every MAC start pulse is counted, wherever it falls
    if (o_mac_tx_start) begin
      start_count++;
    end
    i_engine_fifo_empty       = fifo_q.size() == 0;
    i_engine_packet_available = fifo_q.size() != 0;
    i_engine_fifo_rd_data     = (fifo_q.size() != 0) ? fifo_q[0] : '0;
    i_engine_bytes_last_word  = fifo_lwdv;
  endtask

  task automatic send_packet(input int p, input int n, input logic [LWDV_W-1:0] k);
    logic [63:0] bits;
    int          cycles;
    bit          seen;
    for (int i = 0; i < n; i++) begin
      take_bits(DATA_W, bits);
      fifo_q.push_back(bits);
      exp_beats.push_back(expected_beat(bits, i == n - 1, k));
    end
    exp_len.push_back(n);
    fifo_lwdv = k;
    cycles = 0;
    seen = 1'b0;
    // Packet stays at the head until the extractor has read all of it
    while (!seen) begin
      @(negedge clk);
      engine_step();
      seen = o_engine_packet_read;
      cycles++;
      if (!seen && cycles > WAIT_LIMIT) begin
        abort_run($sformatf("packet %0d was never read from the engine FIFO", p));
      end
    end
  endtask

  initial begin
    logic [63:0]       bits;
    int                len;
    logic [LWDV_W-1:0] k;
    int                cycles;
    i_engine_packet_available = 1'b0;
    i_engine_fifo_empty       = 1'b1;
    i_engine_fifo_rd_data     = '0;
    i_engine_bytes_last_word  = '0;
    fifo_lwdv      = '0;
    pop_pending    = 1'b0;
    lfsr_q         = LFSR_SEED;
    mismatch_count = 0;
    failure_count  = 0;
    pkt_read_count = 0;
    start_count    = 0;
    // Ack delays of 0 to 5 cycles drawn up front
    for (int p = 0; p < NUM_PKT; p++) begin
      take_bits(3, bits);
      ack_delay[p] = int'(bits[2:0]) % 6;
    end
    // Reset and boot sweep followed by a quiet stretch
    cycles = 0;
    do begin
      @(negedge clk);
      engine_step();
      check_quiet();
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        abort_run("reset was never released");
      end
    end while (areset);
    for (int i = 0; i < QUIET_CYCLES; i++) begin
      @(negedge clk);
      engine_step();
      check_quiet();
    end
    // First nine packets sweep every byte count
    for (int p = 0; p < NUM_PKT; p++) begin
      take_bits(4, bits);
      len = 2 + int'(bits[3:0]) % 11;
      if (p < 9) begin
        k = LWDV_W'(p);
      end else begin
        take_bits(4, bits);
        k = LWDV_W'(int'(bits[3:0]) % 9);
      end
      send_packet(p, len, k);
    end
    // Drain the ring
    cycles = 0;
    while (!mac_done) begin
      @(negedge clk);
      engine_step();
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        abort_run("MAC side never received every packet");
      end
    end
    for (int i = 0; i < QUIET_CYCLES; i++) begin
      @(negedge clk);
      engine_step();
      check_quiet();
    end
    check_value("packet_read pulses", BEAT_W'(pkt_read_count), BEAT_W'(NUM_PKT));
    check_value("mac_tx_start pulses", BEAT_W'(start_count), BEAT_W'(NUM_PKT));
    finish_run();
  end

  // ------------------------------------------------
  // MAC side ack and beat compare
  // ------------------------------------------------

  initial begin : mac_side
    int                cycles;
    int                n;
    int                d;
    bit                started;
    logic [BEAT_W-1:0] want;
    i_mac_tx_ack = 1'b0;
    mac_done     = 1'b0;
    for (int p = 0; p < NUM_PKT; p++) begin
      cycles = 0;
      started = 1'b0;
      while (!started) begin
        @(negedge clk);
        check_mac_idle();
        started = o_mac_tx_start;
        cycles++;
        if (!started && cycles > WAIT_LIMIT) begin
          abort_run($sformatf("no MAC start for packet %0d", p));
        end
      end
      if (exp_len.size() == 0) begin
        abort_run("MAC start with no packet sent");
      end
      n = exp_len.pop_front();
      d = (p == HOLD_IDX) ? HOLD_CYCLES : ack_delay[p];
      // No beats and no second start before the ack
      for (int i = 0; i < d; i++) begin
        @(negedge clk);
        check_mac_idle();
        check_value("o_mac_tx_start", BEAT_W'(o_mac_tx_start), '0);
      end
      i_mac_tx_ack = 1'b1;
      @(negedge clk);
      i_mac_tx_ack = 1'b0;
      check_mac_idle();
      check_value("o_mac_tx_start", BEAT_W'(o_mac_tx_start), '0);
      // Full beats then the repacked one back to back
      for (int i = 0; i < n; i++) begin
        @(negedge clk);
        want = exp_beats.pop_front();
        check_value("o_mac_tx_data_valid", BEAT_W'(o_mac_tx_data_valid),
                    BEAT_W'(want[BEAT_W-1:DATA_W]));
        check_value("o_mac_tx_data", BEAT_W'(o_mac_tx_data), BEAT_W'(want[DATA_W-1:0]));
      end
    end
    mac_done = 1'b1;
  end

endmodule

/* nts_extractor.f */
nts_extractor_pkg.sv
nts_buffer_ram.sv
nts_buffer_table.sv
nts_engine_reader.sv
nts_mac_tx.sv
nts_extractor.sv
tb_clock_gen.sv
tb_nts_extractor.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the extractor regression

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_nts_extractor -f nts_extractor.f \
  || { echo "Verilator build failed"; exit 1; }

# Output is kept in memory and searched for the pass line
out="$(./obj_dir/Vtb_nts_extractor)"
echo "$out"
echo "$out" | grep -qx "Regression passed" && exit 0 || exit 1
